/* files.f */
+incdir+design
design/icache_pkg.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache_ctrl.sv
design/icache_top.sv
tb/icache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = files.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: sim clean

# build, run, then decide from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb/icache_tb.sv */
`include "icache_config.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT_CYCLES = 20000;   // ~300 random fetches at <20 cycles each
    localparam int          L2_LAT_MIN     = 1;
    localparam int          L2_LAT_MAX     = 6;
    localparam logic [31:0] WORD_BASE      = 32'h5a00_0000;   // L2 word = word address + base

    logic                      clk;
    logic                      rst;
    logic                      if_en;
    logic [`IC_ADDR_W-1:0]     if_addr;
    logic [`IC_WORD_W-1:0]     cpu_data;
    logic                      data_rdy;
    logic                      miss_stall;
    logic                      ic_en;
    logic                      l2_rdy;
    logic [`IC_BLOCK_W-1:0]    l2_block;
    logic                      irq;
    logic [`IC_L2_ADDR_W-1:0]  l2_addr;

    // reference cache state
    bit                        ref_valid [2][`IC_SETS];
    logic [`IC_TAG_W-1:0]      ref_tag [2][`IC_SETS];
    bit                        ref_lru [`IC_SETS];     // way named here is the next victim

    int busy_left;          // cycles of grant still held low
    int granted_cycles;     // cycles the request has been seen with grant
    logic prev_ic_en;
    int err_value;
    int err_other;
    int checks;
    int cycle_count;

    icache_top u_icache_top (
        .clk        (clk),
        .rst        (rst),
        .if_en      (if_en),
        .if_addr    (if_addr),
        .cpu_data   (cpu_data),
        .data_rdy   (data_rdy),
        .miss_stall (miss_stall),
        .ic_en      (ic_en),
        .l2_rdy     (l2_rdy),
        .l2_block   (l2_block),
        .irq        (irq),
        .l2_addr    (l2_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] pattern_word(input logic [`IC_ADDR_W-1:0] addr);
        return {2'b00, addr} + WORD_BASE;
    endfunction

    function automatic logic [`IC_BLOCK_W-1:0] pattern_block(
        input logic [`IC_L2_ADDR_W-1:0] baddr
    );
        logic [`IC_BLOCK_W-1:0] blk;
        for (int i = 0; i < 4; i++) begin
            blk[i*32 +: 32] = pattern_word({baddr, i[1:0]});   // word 0 in the low bits
        end
        return blk;
    endfunction

    function automatic logic [`IC_ADDR_W-1:0] make_addr(input logic [19:0] tag,
                                                         input logic [7:0] idx,
                                                         input logic [1:0] off);
        return {tag, idx, off};
    endfunction

    // returns 1 on a miss and updates the model like a fill would
    function automatic bit model_access(input logic [`IC_ADDR_W-1:0] addr);
        logic [`IC_TAG_W-1:0]   t;
        logic [`IC_INDEX_W-1:0] s;
        int                     w;
        t = addr[29:10];
        s = addr[9:2];
        w = -1;
        for (int i = 0; i < 2; i++) begin
            if (ref_valid[i][s] && ref_tag[i][s] == t) begin
                w = i;
            end
        end
        if (w >= 0) begin
            ref_lru[s] = (w == 0);                         // hit way becomes most recent
            return 1'b0;
        end
        if (!ref_valid[0][s]) begin
            w = 0;
        end else if (!ref_valid[1][s]) begin
            w = 1;
        end else begin
            w = ref_lru[s];
        end
        ref_valid[w][s] = 1'b1;
        ref_tag[w][s]   = t;
        ref_lru[s]      = (w == 0);
        return 1'b1;
    endfunction

    // L2 model stepped once per falling edge
    task automatic step_l2(input int latency);
        prev_ic_en = ic_en;
        ic_en      = (busy_left == 0);
        if (busy_left > 0) begin
            busy_left--;
        end
        l2_rdy = 1'b0;
        if (irq && ic_en && prev_ic_en) begin              // cache is waiting with grant
            granted_cycles++;
            if (granted_cycles >= latency) begin
                l2_rdy         = 1'b1;
                l2_block       = pattern_block(l2_addr);
                granted_cycles = 0;
            end
        end
    endtask

    task automatic fetch(input string name, input logic [`IC_ADDR_W-1:0] addr, input int busy,
                         input int latency, output logic [31:0] word, output bit missed,
                         output bit saw_irq, output int rdy_cycle);
        int cyc;
        bit done;
        missed         = 1'b0;
        saw_irq        = 1'b0;
        done           = 1'b0;
        cyc            = 0;
        word           = '0;
        rdy_cycle      = -1;
        busy_left      = busy;
        granted_cycles = 0;
        @(negedge clk);
        if_en   = 1'b1;
        if_addr = addr;
        step_l2(latency);
        while (!done) begin
            #1;
            if (missed && !miss_stall) begin
                $display("miss_stall dropped before the fill at %h", addr);
                err_other++;
            end
            if (miss_stall) missed = 1'b1;
            if (irq) saw_irq = 1'b1;
            if (missed && cyc > 0 && !irq) begin
                $display("request to L2 dropped during a miss at %h", addr);
                err_other++;
            end
            if (data_rdy && miss_stall && !ic_en) begin
                $display("data_rdy on a miss while the L2 grant is low at %h", addr);
                err_other++;
            end
            if (missed && (data_rdy != l2_rdy)) begin
                $display("data_rdy on a miss not in the cycle of the L2 block at %h", addr);
                err_other++;
            end
            if (l2_rdy && l2_addr != addr[29:2]) begin
                $display("FAILED %s l2_addr at %h expected %h actual %h",
                         name, addr, addr[29:2], l2_addr);
                err_value++;
            end
            if (data_rdy) begin
                word      = cpu_data;
                rdy_cycle = cyc;
                done      = 1'b1;
            end else begin
                @(negedge clk);
                cyc++;
                step_l2(latency);
            end
        end
        @(negedge clk);
        if_en  = 1'b0;
        l2_rdy = 1'b0;
        ic_en  = 1'b1;
        #1;
        if (irq) begin
            $display("request to L2 still high after the fetch of %h completed", addr);
            err_other++;
        end
        if (miss_stall || data_rdy) begin
            $display("miss_stall or data_rdy high with no fetch after %h", addr);
            err_other++;
        end
    endtask

    // 1 or 0 in want_miss is the outcome the test expects and -1 leaves it to the model
    task automatic check_fetch(input string name, input logic [`IC_ADDR_W-1:0] addr,
                               input int busy, input int latency, input int want_miss);
        bit          exp_miss;
        logic [31:0] exp_word;
        logic [31:0] word;
        bit          missed;
        bit          saw_irq;
        int          rdy_cycle;
        exp_miss = model_access(addr);
        exp_word = pattern_word(addr);
        fetch(name, addr, busy, latency, word, missed, saw_irq, rdy_cycle);
        checks++;
        if (want_miss >= 0 && exp_miss != want_miss[0]) begin
            $display("%s: reference model does not give the outcome the test expects", name);
            err_other++;
        end
        if (word !== exp_word) begin
            $display("FAILED %s word at %h expected %h actual %h", name, addr, exp_word, word);
            err_value++;
        end
        if (missed != exp_miss) begin
            $display("FAILED %s miss at %h expected %0d actual %0d", name, addr, exp_miss, missed);
            err_value++;
        end
        if (saw_irq != exp_miss) begin
            $display("FAILED %s irq at %h expected %0d actual %0d", name, addr, exp_miss, saw_irq);
            err_value++;
        end
        if (!exp_miss && rdy_cycle != 0) begin
            $display("FAILED %s hit latency expected 0 actual %0d", name, rdy_cycle);
            err_value++;
        end
    endtask

    task automatic cold_miss_then_hit();
        check_fetch("cold_miss_then_hit", make_addr(20'h0_0123, 8'h10, 2'd1), 0, 3, 1);
        check_fetch("cold_miss_then_hit", make_addr(20'h0_0123, 8'h10, 2'd1), 0, 3, 0);
    endtask

    task automatic word_select();
        for (int off = 0; off < 4; off++) begin
            check_fetch("word_select", make_addr(20'h0_0456, 8'h20, off[1:0]), 0, 2,
                        (off == 0) ? 1 : 0);
        end
    endtask

    task automatic two_way_conflict();
        check_fetch("two_way_conflict", make_addr(20'h0_0a01, 8'h30, 2'd0), 0, 1, 1);
        check_fetch("two_way_conflict", make_addr(20'h0_0a02, 8'h30, 2'd1), 0, 4, 1);
        check_fetch("two_way_conflict", make_addr(20'h0_0a03, 8'h30, 2'd2), 0, 2, 1);  // evicts a01
        check_fetch("two_way_conflict", make_addr(20'h0_0a03, 8'h30, 2'd3), 0, 2, 0);
        check_fetch("two_way_conflict", make_addr(20'h0_0a01, 8'h30, 2'd0), 0, 6, 1);
        check_fetch("two_way_conflict", make_addr(20'h0_0a03, 8'h30, 2'd1), 0, 2, 0);
        check_fetch("two_way_conflict", make_addr(20'h0_0a02, 8'h30, 2'd2), 0, 3, 1);
    endtask

    task automatic lru_on_hit();
        check_fetch("lru_on_hit", make_addr(20'h0_0b0a, 8'h40, 2'd0), 0, 2, 1);   // A
        check_fetch("lru_on_hit", make_addr(20'h0_0b0b, 8'h40, 2'd0), 0, 2, 1);   // B
        check_fetch("lru_on_hit", make_addr(20'h0_0b0a, 8'h40, 2'd1), 0, 2, 0);   // A hit
        check_fetch("lru_on_hit", make_addr(20'h0_0b0c, 8'h40, 2'd0), 0, 2, 1);   // C takes B's way
        check_fetch("lru_on_hit", make_addr(20'h0_0b0a, 8'h40, 2'd2), 0, 2, 0);
        check_fetch("lru_on_hit", make_addr(20'h0_0b0b, 8'h40, 2'd3), 0, 2, 1);
    endtask

    task automatic l2_busy();
        check_fetch("l2_busy", make_addr(20'h0_0c0d, 8'h50, 2'd2), 5, 2, 1);
        check_fetch("l2_busy", make_addr(20'h0_0c0d, 8'h50, 2'd3), 3, 2, 0);   // hits ignore grant
    endtask

    task automatic random_stream();
        logic [31:0] r;
        int          busy;
        int          lat;
        for (int n = 0; n < 300; n++) begin
            r    = $urandom;
            busy = (r[8:6] == 3'd0) ? int'(r[10:9]) + 1 : 0;
            lat  = $urandom_range(L2_LAT_MAX, L2_LAT_MIN);
            check_fetch("random_stream",
                        make_addr({18'h0, r[1:0]}, {6'b100000, r[3:2]}, r[5:4]), busy, lat, -1);
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d value, %0d other, over %0d fetches", err_value, err_other, checks);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, run still going after %0d cycles", TIMEOUT_CYCLES);
            report_counts();
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'ha192_ff4d));
        rst            = 1'b1;
        if_en          = 1'b0;
        if_addr        = '0;
        ic_en          = 1'b1;
        l2_rdy         = 1'b0;
        l2_block       = '0;
        busy_left      = 0;
        granted_cycles = 0;
        prev_ic_en     = 1'b1;
        err_value      = 0;
        err_other      = 0;
        checks         = 0;
        cycle_count    = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        cold_miss_then_hit();
        word_select();
        two_way_conflict();
        lru_on_hit();
        l2_busy();
        random_stream();
        @(negedge clk);
        report_counts();
        if (err_value + err_other == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* design/icache_top.sv */
`include "icache_config.svh"

module icache_top import icache_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      if_en,
    input  logic [`IC_ADDR_W-1:0]     if_addr,
    output logic [`IC_WORD_W-1:0]     cpu_data,
    output logic                      data_rdy,
    output logic                      miss_stall,
    input  logic                      ic_en,
    input  logic                      l2_rdy,
    input  logic [`IC_BLOCK_W-1:0]    l2_block,
    output logic                      irq,
    output logic [`IC_L2_ADDR_W-1:0]  l2_addr
);

    logic [`IC_INDEX_W-1:0]  index;
    logic [`IC_TAG_W-1:0]    tag_wd;
    logic                    block0_we;
    logic                    block1_we;
    logic                    lru_we;
    ic_way_e                 lru_way;
    logic [`IC_TAG_W:0]      tag0_rd;
    logic [`IC_TAG_W:0]      tag1_rd;
    logic                    lru;
    logic [`IC_BLOCK_W-1:0]  data0_rd;
    logic [`IC_BLOCK_W-1:0]  data1_rd;

    icache_ctrl u_icache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .if_en      (if_en),
        .if_addr    (if_addr),
        .cpu_data   (cpu_data),
        .data_rdy   (data_rdy),
        .miss_stall (miss_stall),
        .ic_en      (ic_en),
        .l2_rdy     (l2_rdy),
        .l2_block   (l2_block),
        .irq        (irq),
        .l2_addr    (l2_addr),
        .tag0_rd    (tag0_rd),
        .tag1_rd    (tag1_rd),
        .lru        (lru),
        .data0_rd   (data0_rd),
        .data1_rd   (data1_rd),
        .index      (index),
        .tag_wd     (tag_wd),
        .block0_we  (block0_we),
        .block1_we  (block1_we),
        .lru_we     (lru_we),
        .lru_way    (lru_way)
    );

    icache_tag_store u_icache_tag_store (
        .clk       (clk),
        .rst       (rst),
        .index     (index),
        .tag_wd    (tag_wd),
        .block0_we (block0_we),
        .block1_we (block1_we),
        .lru_we    (lru_we),
        .lru_way   (lru_way),
        .tag0_rd   (tag0_rd),
        .tag1_rd   (tag1_rd),
        .lru       (lru)
    );

    icache_data_store u_icache_data_store (
        .clk       (clk),
        .index     (index),
        .l2_block  (l2_block),
        .block0_we (block0_we),
        .block1_we (block1_we),
        .data0_rd  (data0_rd),
        .data1_rd  (data1_rd)
    );

    // miss cycle is followed by a raised request
    a_miss_raises_irq: assert property (
        @(posedge clk) disable iff (rst)
        (miss_stall && !irq) |=> irq
    );

    // fill cycle, then one write_ic cycle, then back to lookup
    a_fill_returns: assert property (
        @(posedge clk) disable iff (rst)
        (data_rdy && miss_stall) |=>
            (u_icache_ctrl.state == write_ic) ##1 (u_icache_ctrl.state == ic_access)
    );

endmodule

/* design/icache_ctrl.sv */
`include "icache_config.svh"

module icache_ctrl import icache_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    // fetch side
    input  logic                      if_en,
    input  logic [`IC_ADDR_W-1:0]     if_addr,
    output logic [`IC_WORD_W-1:0]     cpu_data,
    output logic                      data_rdy,
    output logic                      miss_stall,
    // L2 side
    input  logic                      ic_en,
    input  logic                      l2_rdy,
    input  logic [`IC_BLOCK_W-1:0]    l2_block,
    output logic                      irq,
    output logic [`IC_L2_ADDR_W-1:0]  l2_addr,
    // tag store
    input  logic [`IC_TAG_W:0]        tag0_rd,
    input  logic [`IC_TAG_W:0]        tag1_rd,
    input  logic                      lru,
    // data store
    input  logic [`IC_BLOCK_W-1:0]    data0_rd,
    input  logic [`IC_BLOCK_W-1:0]    data1_rd,
    // array control
    output logic [`IC_INDEX_W-1:0]    index,
    output logic [`IC_TAG_W-1:0]      tag_wd,
    output logic                      block0_we,
    output logic                      block1_we,
    output logic                      lru_we,
    output ic_way_e                   lru_way
);

    ic_state_e                state;
    ic_state_e                next_state;
    logic [`IC_TAG_W-1:0]     fetch_tag;
    logic [`IC_OFFSET_W-1:0]  word_sel;
    logic                     hit0;
    logic                     hit1;
    logic                     hit;
    ic_way_e                  hit_way;
    ic_way_e                  victim;
    logic                     fill;
    logic [`IC_BLOCK_W-1:0]   sel_block;

    // address split: tag | index | word
    assign fetch_tag = if_addr[`IC_ADDR_W-1 -: `IC_TAG_W];
    assign index     = if_addr[`IC_OFFSET_W +: `IC_INDEX_W];
    assign word_sel  = if_addr[`IC_OFFSET_W-1:0];
    assign l2_addr   = if_addr[`IC_ADDR_W-1:`IC_OFFSET_W];   // block address
    assign tag_wd    = fetch_tag;

    // tag compare, valid bit on top
    assign hit0    = tag0_rd[`IC_TAG_W] && (tag0_rd[`IC_TAG_W-1:0] == fetch_tag);
    assign hit1    = tag1_rd[`IC_TAG_W] && (tag1_rd[`IC_TAG_W-1:0] == fetch_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1 ? way1 : way0;

    // victim: free way0, then free way1, else lru
    always_comb begin
        if (!tag0_rd[`IC_TAG_W]) begin
            victim = way0;
        end else if (!tag1_rd[`IC_TAG_W]) begin
            victim = way1;
        end else if (lru) begin
            victim = way1;
        end else begin
            victim = way0;
        end
    end

    // refill cycle: granted and block on the bus
    assign fill = (state == ic_access_l2) && ic_en && l2_rdy;

    // word select, L2 block bypasses the arrays during a fill
    always_comb begin
        if (fill) begin
            sel_block = l2_block;
        end else if (hit1) begin
            sel_block = data1_rd;
        end else begin
            sel_block = data0_rd;
        end
    end

    assign cpu_data = sel_block[word_sel * `IC_WORD_W +: `IC_WORD_W];

    // next state and array strobes
    always_comb begin
        next_state = state;
        data_rdy   = 1'b0;
        miss_stall = 1'b0;
        block0_we  = 1'b0;
        block1_we  = 1'b0;
        lru_we     = 1'b0;
        lru_way    = hit_way;
        case (state)
            ic_access: begin
                if (if_en) begin
                    if (hit) begin
                        data_rdy = 1'b1;            // zero-cycle hit
                        lru_we   = 1'b1;
                        lru_way  = hit_way;
                    end else begin
                        miss_stall = 1'b1;
                        next_state = ic_access_l2;
                    end
                end
            end
            ic_access_l2: begin
                miss_stall = 1'b1;
                if (!ic_en) begin
                    next_state = wait_l2_busy;      // L2 serving someone else
                end else if (l2_rdy) begin
                    data_rdy   = 1'b1;              // requested word straight through
                    block0_we  = (victim == way0);
                    block1_we  = (victim == way1);
                    lru_we     = 1'b1;
                    lru_way    = victim;
                    next_state = write_ic;
                end
            end
            wait_l2_busy: begin
                miss_stall = 1'b1;
                if (ic_en) begin
                    next_state = ic_access_l2;
                end
            end
            write_ic: begin
                next_state = ic_access;             // arrays took the block last edge
            end
            default: begin
                next_state = ic_access;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ic_access;
            irq   <= 1'b0;
        end else begin
            state <= next_state;
            // request held while the miss is outstanding
            irq   <= (next_state == ic_access_l2) || (next_state == wait_l2_busy);
        end
    end

    // a tag lives in at most one way of a set
    a_one_hit_way: assert property (
        @(posedge clk) disable iff (rst)
        !(hit0 && hit1)
    );

    a_one_block_we: assert property (
        @(posedge clk) disable iff (rst)
        !(block0_we && block1_we)
    );

    a_no_rdy_when_busy: assert property (
        @(posedge clk) disable iff (rst)
        (state == wait_l2_busy) |-> !data_rdy
    );

endmodule

/* design/icache_data_store.sv */
`include "icache_config.svh"

module icache_data_store (
    input  logic                    clk,
    input  logic [`IC_INDEX_W-1:0]  index,
    input  logic [`IC_BLOCK_W-1:0]  l2_block,
    input  logic                    block0_we,
    input  logic                    block1_we,
    output logic [`IC_BLOCK_W-1:0]  data0_rd,
    output logic [`IC_BLOCK_W-1:0]  data1_rd
);

    logic [`IC_BLOCK_W-1:0] block_mem [2][`IC_SETS];   // one block per set and way
    logic [1:0]             way_we;

    assign way_we = {block1_we, block0_we};

    // the whole block from L2 lands in one edge
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way_we[w]) begin
                block_mem[w][index] <= l2_block;
            end
        end
    end

    // both ways read together, the controller picks
    assign data0_rd = block_mem[0][index];
    assign data1_rd = block_mem[1][index];

endmodule

/* design/icache_tag_store.sv */
`include "icache_config.svh"

module icache_tag_store import icache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`IC_INDEX_W-1:0]  index,
    input  logic [`IC_TAG_W-1:0]    tag_wd,
    input  logic                    block0_we,
    input  logic                    block1_we,
    input  logic                    lru_we,
    input  ic_way_e                 lru_way,
    output logic [`IC_TAG_W:0]      tag0_rd,    // {valid, tag}
    output logic [`IC_TAG_W:0]      tag1_rd,    // {valid, tag}
    output logic                    lru
);

    logic [`IC_TAG_W-1:0] tag_mem [2][`IC_SETS];
    logic [`IC_SETS-1:0]  valid_bits [2];
    logic [`IC_SETS-1:0]  lru_bits;              // 1 = way1 is least recent
    logic [1:0]           way_we;

    assign way_we = {block1_we, block0_we};

    // tag arrays
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way_we[w]) begin
                tag_mem[w][index] <= tag_wd;
            end
        end
    end

    // valid and replacement state
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits[0] <= '0;
            valid_bits[1] <= '0;
            lru_bits      <= '0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (way_we[w]) begin
                    valid_bits[w][index] <= 1'b1;           // a fill makes the line live
                end
            end
            if (lru_we) begin
                lru_bits[index] <= (lru_way == way0);       // other way becomes lru
            end
        end
    end

    // asynchronous read of the addressed set
    assign tag0_rd = {valid_bits[0][index], tag_mem[0][index]};
    assign tag1_rd = {valid_bits[1][index], tag_mem[1][index]};
    assign lru     = lru_bits[index];

    // one refill at a time, so only one way may take a tag
    a_single_way_write: assert property (
        @(posedge clk) disable iff (rst)
        !(block0_we && block1_we)
    );

endmodule

/* design/icache_pkg.sv */
package icache_pkg;

    // controller states
    typedef enum logic [1:0] {
        ic_access    = 2'd0,    // lookup, hits served here
        ic_access_l2 = 2'd1,    // request out, wait for l2_rdy
        wait_l2_busy = 2'd2,    // L2 grant low
        write_ic     = 2'd3     // block landed, one cycle
    } ic_state_e;

    // way of a hit or a victim
    typedef enum logic {
        way0 = 1'b0,
        way1 = 1'b1
    } ic_way_e;

endpackage

/* design/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cache geometry
`define IC_INDEX_W      8       // set index bits
`define IC_SETS         256     // sets per way
`define IC_TAG_W        20      // tag bits, valid kept apart
`define IC_OFFSET_W     2       // word offset inside a block

// datapath widths
`define IC_ADDR_W       30      // word address from the core
`define IC_WORD_W       32      // one instruction
`define IC_BLOCK_W      128     // four words per block
`define IC_L2_ADDR_W    28      // block address toward L2

`endif
